// ==== src/bus_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus side definitions: wishbone classic bundles between core and
// serializer, and the byte phases of one external pin frame
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package bus_pkg;

  localparam int wb_width = 32;  // every access is a full word

  // master to slave
  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [wb_width-1:0] adr;
    logic [wb_width-1:0] dat;  // write data, ignored on reads
  } wb_req_t;

  // slave to master
  typedef struct packed {
    logic                ack;
    logic [wb_width-1:0] dat;  // read data, valid with ack
  } wb_rsp_t;

  // frame phase, 0 means no frame in flight
  typedef logic [3:0] phase_t;

  // frame layout
  //   1..4  address bytes, lsb first, write data on uio
  //   5     direction byte, bit 0 set on write
  //   6..9  read data bytes sampled from uio
  localparam phase_t ph_idle    = 4'd0;
  localparam phase_t ph_addr0   = 4'd1;
  localparam phase_t ph_addr3   = 4'd4;
  localparam phase_t ph_dir     = 4'd5;
  localparam phase_t ph_rd0     = 4'd6;
  localparam phase_t frame_last = 4'd9;  // also the ack phase

  localparam logic [7:0] oe_drive = 8'hff;  // uio driven by us
  localparam logic [7:0] oe_float = 8'h00;  // uio driven by memory

endpackage

`default_nettype wire

// ==== src/cpu_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cpu side definitions: opcodes and instruction word layout of the
// accumulator machine, plus its start address
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package cpu_pkg;

  // opcode sits in bits 31:28 of the instruction
  typedef enum logic [3:0] {
    op_load  = 4'd0,  // acc <- mem
    op_store = 4'd1,  // mem <- acc
    op_add   = 4'd2,  // acc <- acc + mem
    op_sub   = 4'd3,  // acc <- acc - mem
    op_jump  = 4'd4,  // pc <- operand
    op_jz    = 4'd5,  // pc <- operand when acc is zero
    op_halt  = 4'd6
  } opcode_t;

  localparam int operand_width = 28;

  // operand is a word address, byte address is operand * 4
  typedef struct packed {
    opcode_t                  op;
    logic [operand_width-1:0] operand;
  } instr_t;

  // first fetch after reset
  localparam logic [31:0] reset_vector = 32'h0000_0000;

endpackage

`default_nettype wire

// ==== src/phase_counter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame phase sequencer, runs 1 to 9 once per start and then idles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module phase_counter (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            start,
  output bus_pkg::phase_t phase
);
  import bus_pkg::*;

  logic running;

  assign running = (phase != ph_idle);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase <= ph_idle;
    end else if (running) begin
      // start has no effect mid frame
      if (phase == frame_last) begin
        phase <= ph_idle;
      end else begin
        phase <= phase + 4'd1;
      end
    end else if (start) begin
      phase <= ph_addr0;
    end
  end

endmodule

`default_nettype wire

// ==== src/bus_serializer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wishbone slave that turns each word access into a byte frame on the
// pins: address and write bytes out, direction byte, read bytes back in
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module bus_serializer (
  input  logic             clk,
  input  logic             rst_n,
  input  bus_pkg::wb_req_t wb_req,
  output bus_pkg::wb_rsp_t wb_rsp,
  output logic             start,
  input  bus_pkg::phase_t  phase,
  output logic [7:0]       uo_out,
  output logic [7:0]       uio_out,
  output logic [7:0]       uio_oe,
  input  logic [7:0]       uio_in
);
  import bus_pkg::*;

  phase_t          phase_nxt;     // value the counter takes at this edge
  logic [7:0]      uo_nxt;
  logic [7:0]      uio_nxt;
  logic            drive_nxt;
  logic [2:0][7:0] rd_bytes;      // read bytes 0..2, byte 3 comes live
  logic            req_live;

  assign req_live = wb_req.cyc & wb_req.stb;
  assign start    = req_live && (phase == ph_idle);

  // mirror of the counter step, so the pins line up with the phase
  always_comb begin
    if (start) begin
      phase_nxt = ph_addr0;
    end else if (phase == ph_idle || phase == frame_last) begin
      phase_nxt = ph_idle;
    end else begin
      phase_nxt = phase + 4'd1;
    end
  end

  // byte select for the next phase
  always_comb begin
    uo_nxt  = 8'h00;
    uio_nxt = 8'h00;
    case (phase_nxt)
      ph_addr0: begin
        uo_nxt  = wb_req.adr[7:0];
        uio_nxt = wb_req.we ? wb_req.dat[7:0] : 8'h00;
      end
      ph_addr0 + 4'd1: begin
        uo_nxt  = wb_req.adr[15:8];
        uio_nxt = wb_req.we ? wb_req.dat[15:8] : 8'h00;
      end
      ph_addr0 + 4'd2: begin
        uo_nxt  = wb_req.adr[23:16];
        uio_nxt = wb_req.we ? wb_req.dat[23:16] : 8'h00;
      end
      ph_addr3: begin
        uo_nxt  = wb_req.adr[31:24];
        uio_nxt = wb_req.we ? wb_req.dat[31:24] : 8'h00;
      end
      ph_dir: uo_nxt = {7'b000_0000, wb_req.we};  // bit 0 marks a write
      default: ;                                  // read phases and idle
    endcase
  end

  assign drive_nxt = (phase_nxt >= ph_addr0) && (phase_nxt <= ph_dir);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      uo_out  <= 8'h00;
      uio_out <= 8'h00;
      uio_oe  <= oe_float;
    end else begin
      uo_out  <= uo_nxt;
      uio_out <= uio_nxt;
      uio_oe  <= drive_nxt ? oe_drive : oe_float;
    end
  end

  // capture memory bytes at the end of phases 6..8
  always_ff @(posedge clk) begin
    case (phase)
      ph_rd0:         rd_bytes[0] <= uio_in;
      ph_rd0 + 4'd1:  rd_bytes[1] <= uio_in;
      ph_rd0 + 4'd2:  rd_bytes[2] <= uio_in;
      default: ;
    endcase
  end

  // ack in the last phase, top byte straight from the pins
  assign wb_rsp.ack = (phase == frame_last);
  assign wb_rsp.dat = {uio_in, rd_bytes[2], rd_bytes[1], rd_bytes[0]};

endmodule

`default_nettype wire

// ==== src/cpu_core.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32-bit accumulator cpu, wishbone classic master, one access at a time
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module cpu_core (
  input  logic             clk,
  input  logic             rst_n,
  output bus_pkg::wb_req_t wb_req,
  input  bus_pkg::wb_rsp_t wb_rsp
);
  import bus_pkg::*;
  import cpu_pkg::*;

  typedef enum logic [1:0] {
    st_fetch,
    st_operand,
    st_execute,
    st_halted
  } state_t;

  state_t              state;
  logic [wb_width-1:0] pc;
  logic [wb_width-1:0] acc;
  instr_t              ir;
  logic [wb_width-1:0] operand_adr;  // byte address of the operand word
  logic [wb_width-1:0] jz_target;
  logic                acked;

  // idle-to-busy read request, used for every fetch
  function automatic wb_req_t bus_read(input logic [wb_width-1:0] adr);
    wb_req_t req;
    req     = '0;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.adr = adr;
    return req;
  endfunction

  assign acked       = wb_req.cyc & wb_rsp.ack;
  assign operand_adr = {2'b00, ir.operand, 2'b00};
  assign jz_target   = (acc == '0) ? operand_adr : pc;  // pc already points past jz

  // instruction register loads on the fetch ack
  always_ff @(posedge clk) begin
    if (state == st_fetch && acked) begin
      ir <= instr_t'(wb_rsp.dat);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state  <= st_fetch;
      pc     <= reset_vector;
      acc    <= '0;
      wb_req <= '0;
    end else begin
      case (state)
        st_fetch: begin
          if (!wb_req.cyc) begin
            wb_req <= bus_read(pc);  // bus was idle, start fetch
          end else if (acked) begin
            pc     <= pc + 32'd4;
            wb_req <= '0;
            state  <= st_execute;
          end
        end

        st_execute: begin
          case (ir.op)
            op_load, op_add, op_sub, op_store: begin
              wb_req.cyc <= 1'b1;
              wb_req.stb <= 1'b1;
              wb_req.we  <= (ir.op == op_store);
              wb_req.adr <= operand_adr;
              wb_req.dat <= acc;
              state      <= st_operand;
            end
            op_jump: begin
              pc     <= operand_adr;
              wb_req <= bus_read(operand_adr);
              state  <= st_fetch;
            end
            op_jz: begin
              pc     <= jz_target;
              wb_req <= bus_read(jz_target);
              state  <= st_fetch;
            end
            op_halt: state <= st_halted;
            default: begin
              // undefined opcode acts as a nop
              wb_req <= bus_read(pc);
              state  <= st_fetch;
            end
          endcase
        end

        st_operand: begin
          if (acked) begin
            case (ir.op)
              op_load: acc <= wb_rsp.dat;
              op_add:  acc <= acc + wb_rsp.dat;
              op_sub:  acc <= acc - wb_rsp.dat;
              default: ;  // store leaves acc alone
            endcase
            wb_req <= '0;
            state  <= st_fetch;  // fetch issued next cycle
          end
        end

        default: begin
          wb_req <= '0;  // halted for good
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/cpu_handler.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// pin-limited cpu system top: core, bus serializer and frame counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module cpu_handler (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       ena,      // always high when powered
  input  logic [7:0] ui_in,
  output logic [7:0] uo_out,
  input  logic [7:0] uio_in,
  output logic [7:0] uio_out,
  output logic [7:0] uio_oe
);
  import bus_pkg::*;

  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  phase_t  phase;
  logic    start;
  logic    unused_inputs;

  cpu_core u_core (
    .clk    (clk),
    .rst_n  (rst_n),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  bus_serializer u_serializer (
    .clk     (clk),
    .rst_n   (rst_n),
    .wb_req  (wb_req),
    .wb_rsp  (wb_rsp),
    .start   (start),
    .phase   (phase),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .uio_in  (uio_in)
  );

  phase_counter u_phase (
    .clk   (clk),
    .rst_n (rst_n),
    .start (start),
    .phase (phase)
  );

  assign unused_inputs = ^{ena, ui_in};  // inputs with no function here

endmodule

`default_nettype wire

// ==== sim/cpu_handler_asserts.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// frame and pin rules of the bus serializer, bound into every instance
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module cpu_handler_asserts (
  input logic             clk,
  input logic             rst_n,
  input bus_pkg::wb_req_t wb_req,
  input bus_pkg::wb_rsp_t wb_rsp,
  input logic             start,
  input bus_pkg::phase_t  phase,
  input logic [7:0]       uio_oe
);
  import bus_pkg::*;

  // whole byte drives in phases 1..5, floats otherwise
  oe_in_phase: assert property (@(posedge clk) disable iff (!rst_n)
    uio_oe == (((phase >= ph_addr0) && (phase <= ph_dir)) ? oe_drive : oe_float))
    else $error("uio_oe %h does not match phase %0d", uio_oe, phase);

  // ack closes the frame a live request started
  ack_at_last: assert property (@(posedge clk) disable iff (!rst_n)
    wb_rsp.ack |-> wb_req.cyc && wb_req.stb && $past(start, frame_last))
    else $error("ack raised in phase %0d without a matching start", phase);

  // counts up by one or drops back to idle
  phase_steps: assert property (@(posedge clk) disable iff (!rst_n)
    (phase == ph_idle) || (phase == $past(phase) + 4'd1))
    else $error("phase jumped to %0d", phase);

endmodule

bind bus_serializer cpu_handler_asserts u_asserts (
  .clk    (clk),
  .rst_n  (rst_n),
  .wb_req (wb_req),
  .wb_rsp (wb_rsp),
  .start  (start),
  .phase  (phase),
  .uio_oe (uio_oe)
);

`default_nettype wire

// ==== sim/tb_cpu_handler.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the pin-limited cpu: pin-level memory model, reference
// model of the accumulator isa, and frame by frame compare
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ns
`default_nettype none

module tb_cpu_handler;
  import bus_pkg::*;
  import cpu_pkg::*;

  localparam int mem_words    = 64;
  localparam int quiet_cycles = 60;   // window after halt with no frame
  localparam int zero_word    = 31;   // holds 0 for the jz tests

  logic       clk;
  logic       rst_n;
  logic       ena;
  logic [7:0] ui_in;
  logic [7:0] uo_out;
  logic [7:0] uio_in;
  logic [7:0] uio_out;
  logic [7:0] uio_oe;

  logic [31:0] mem     [mem_words];  // what the pins talk to
  logic [31:0] ref_mem [mem_words];
  logic [31:0] ref_pc;
  logic [31:0] ref_acc;
  logic [31:0] lfsr_state = 32'h6216;

  // expected and observed access sequences
  logic [31:0] exp_adr[$];
  logic [31:0] exp_dat[$];
  logic        exp_dir[$];
  logic [31:0] obs_adr[$];
  logic [31:0] obs_dat[$];
  logic        obs_dir[$];

  int          frame_cnt = 0;  // phase as seen from the pins
  logic [31:0] fr_adr;
  logic [31:0] fr_dat;
  logic        fr_dir;
  logic [31:0] rd_word;
  int          frames_seen = 0;
  int          frames_checked = 0;
  int          errors = 0;
  int          checks = 0;

  cpu_handler dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .ena     (ena),
    .ui_in   (ui_in),
    .uo_out  (uo_out),
    .uio_in  (uio_in),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];  // x^32 + x^22 + x^2 + x + 1
    return {s[30:0], fb};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] make_instr(input opcode_t op, input int word);
    instr_t w;
    w.op      = op;
    w.operand = 28'(word);
    return w;
  endfunction

  task automatic check_addr(input string name, input logic [wb_width-1:0] got,
                            input logic [wb_width-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [wb_width-1:0] got,
                            input logic [wb_width-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_dir(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s got %h exp %h", name, got, exp);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s got %h exp %h", name, got, exp);
    end
  endtask

  function automatic void expect_access(input logic [31:0] adr, input logic we,
                                        input logic [31:0] dat);
    exp_adr.push_back(adr);
    exp_dir.push_back(we);
    exp_dat.push_back(dat);  // zero on reads, uio_out stays low
  endfunction

  // one instruction of the isa on ref_mem, returns 1 on halt
  function automatic logic ref_step();
    instr_t      ins;
    logic [31:0] opa;
    logic [31:0] opw;
    logic        halted;
    halted = 1'b0;
    ins = instr_t'(ref_mem[ref_pc[7:2]]);
    expect_access(ref_pc, 1'b0, 32'h0);  // fetch
    ref_pc = ref_pc + 32'd4;
    opa = 32'(ins.operand) * 32'd4;
    opw = ref_mem[opa[7:2]];
    case (ins.op)
      op_load: begin
        expect_access(opa, 1'b0, 32'h0);
        ref_acc = opw;
      end
      op_add: begin
        expect_access(opa, 1'b0, 32'h0);
        ref_acc = ref_acc + opw;
      end
      op_sub: begin
        expect_access(opa, 1'b0, 32'h0);
        ref_acc = ref_acc - opw;
      end
      op_store: begin
        expect_access(opa, 1'b1, ref_acc);
        ref_mem[opa[7:2]] = ref_acc;
      end
      op_jump: ref_pc = opa;
      op_jz: begin
        if (ref_acc == 32'h0) ref_pc = opa;
      end
      op_halt: halted = 1'b1;
      default: ;
    endcase
    return halted;
  endfunction

  function automatic int data_slot();
    return 32 + int'(rand_bits(4));  // operands read from words 32..47
  endfunction

  function automatic int result_slot();
    return 48 + int'(rand_bits(4));  // stores land in words 48..63
  endfunction

  task automatic fill_memory();
    int i;
    for (i = 0; i < mem_words; i++) begin
      mem[i] = rand_bits(32);
    end
    mem[zero_word] = 32'h0;
  endtask

  // load, add, sub and store with a read back
  task automatic build_arith_program();
    int d0;
    int r0;
    fill_memory();
    d0 = data_slot();
    r0 = result_slot();
    mem[0] = make_instr(op_load, d0);
    mem[1] = make_instr(op_add, data_slot());
    mem[2] = make_instr(op_sub, data_slot());
    mem[3] = make_instr(op_store, r0);
    mem[4] = make_instr(op_load, r0);
    mem[5] = make_instr(op_add, d0);
    mem[6] = make_instr(op_store, result_slot());
    mem[7] = make_instr(op_halt, 0);
  endtask

  // jz taken and not taken, then a plain jump
  task automatic build_branch_program();
    int d0;
    fill_memory();
    d0 = data_slot();
    mem[d0] = mem[d0] | 32'h1;  // nonzero acc for the untaken jz
    mem[0]  = make_instr(op_load, zero_word);
    mem[1]  = make_instr(op_jz, 4);
    mem[2]  = make_instr(op_store, result_slot());
    mem[3]  = make_instr(op_halt, 0);
    mem[4]  = make_instr(op_load, d0);
    mem[5]  = make_instr(op_jz, 2);
    mem[6]  = make_instr(op_sub, d0);
    mem[7]  = make_instr(op_jz, 10);
    mem[8]  = make_instr(op_store, result_slot());
    mem[9]  = make_instr(op_halt, 0);
    mem[10] = make_instr(op_store, result_slot());
    mem[11] = make_instr(op_jump, 13);
    mem[12] = make_instr(op_halt, 0);
    mem[13] = make_instr(op_add, data_slot());
    mem[14] = make_instr(op_store, result_slot());
    mem[15] = make_instr(op_halt, 0);
  endtask

  // pin-level memory, phases counted from the rise of uio_oe
  always @(negedge clk) begin
    if (frame_cnt != 0 && frame_cnt != frame_last) begin
      frame_cnt = frame_cnt + 1;
    end else if (uio_oe == oe_drive) begin
      frame_cnt = 1;
      frames_seen++;
    end else begin
      frame_cnt = 0;
    end
    uio_in <= 8'h00;
    if (frame_cnt == 0) begin
      check_byte("uo_out", uo_out, 8'h00);
      check_byte("uio_out", uio_out, 8'h00);
      check_byte("uio_oe", uio_oe, oe_float);
    end else if (frame_cnt <= 4) begin
      check_byte("uio_oe", uio_oe, oe_drive);
      fr_adr[8*(frame_cnt-1) +: 8] = uo_out;  // lsb first
      fr_dat[8*(frame_cnt-1) +: 8] = uio_out;
    end else if (frame_cnt == 5) begin
      check_byte("uio_oe", uio_oe, oe_drive);
      check_byte("uo_out", uo_out & 8'hfe, 8'h00);
      fr_dir = uo_out[0];
      if (fr_dir) begin
        mem[fr_adr[7:2]] = fr_dat;
      end else begin
        rd_word = mem[fr_adr[7:2]];
      end
      obs_adr.push_back(fr_adr);
      obs_dir.push_back(fr_dir);
      obs_dat.push_back(fr_dat);
    end else begin
      check_byte("uio_oe", uio_oe, oe_float);
      if (!fr_dir) begin
        uio_in <= rd_word[8*(frame_cnt-6) +: 8];
      end
    end
  end

  // compare each observed frame with the next expected access
  always @(posedge clk) begin : compare_frames
    logic [31:0] a;
    logic [31:0] w;
    logic        d;
    if (obs_adr.size() > 0) begin
      a = obs_adr.pop_front();
      d = obs_dir.pop_front();
      w = obs_dat.pop_front();
      if (exp_adr.size() == 0) begin
        errors++;
        $display("bus frame to address %h came after the program should have halted", a);
      end else begin
        check_addr("adr", a, exp_adr.pop_front());
        check_dir("we", d, exp_dir.pop_front());
        check_word("wdat", w, exp_dat.pop_front());
      end
      frames_checked++;
    end
  end

  task automatic run_program(input logic branch);
    int   i;
    int   cycles;
    int   exp_total;
    int   base_checked;
    int   base_seen;
    logic done;
    @(negedge clk);
    rst_n = 1'b0;
    exp_adr.delete();
    exp_dir.delete();
    exp_dat.delete();
    obs_adr.delete();
    obs_dir.delete();
    obs_dat.delete();
    if (branch) build_branch_program();
    else build_arith_program();
    ref_mem = mem;
    ref_pc  = reset_vector;
    ref_acc = 32'h0;
    done    = 1'b0;
    for (i = 0; i < mem_words && !done; i++) begin
      done = ref_step();
    end
    if (!done) begin
      errors++;
      $display("reference program ran off without reaching halt");
    end
    exp_total    = exp_adr.size();
    base_checked = frames_checked;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    cycles = 0;
    while (frames_checked - base_checked < exp_total && cycles < exp_total * 15 + 50) begin
      @(negedge clk);
      cycles++;
    end
    if (frames_checked - base_checked < exp_total) begin
      errors++;
      $display("timed out with %0d of %0d frames seen", frames_checked - base_checked,
               exp_total);
    end
    base_seen = frames_seen;
    for (cycles = 0; cycles < quiet_cycles; cycles++) begin
      @(negedge clk);
    end
    if (frames_seen != base_seen) begin
      errors++;
      $display("a new frame started after the halt instruction");
    end
    for (i = 0; i < mem_words; i++) begin
      check_word($sformatf("mem[%0d]", i), mem[i], ref_mem[i]);
    end
  endtask

  initial begin
    rst_n  = 1'b0;
    ena    = 1'b1;
    ui_in  = 8'h00;
    uio_in = 8'h00;
    run_program(1'b0);
    run_program(1'b0);
    run_program(1'b0);
    run_program(1'b1);
    run_program(1'b1);
    $display("checks %0d errors %0d frames %0d", checks, errors, frames_checked);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== cpu_handler.f ====
src/bus_pkg.sv
src/cpu_pkg.sv
src/phase_counter.sv
src/bus_serializer.sv
src/cpu_core.sv
src/cpu_handler.sv
sim/cpu_handler_asserts.sv
sim/tb_cpu_handler.sv

// ==== Bender.yml ====
package:
  name: cpu_handler

sources:
  - src/bus_pkg.sv
  - src/cpu_pkg.sv
  - src/phase_counter.sv
  - src/bus_serializer.sv
  - src/cpu_core.sv
  - src/cpu_handler.sv
  - target: test
    files:
      - sim/cpu_handler_asserts.sv
      - sim/tb_cpu_handler.sv
